// ==== include/div_consts.svh ====
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand and result width, rv32
`define DIV_WIDTH 32

// partial remainder carries one extra bit for the compare
`define DIV_REM_WIDTH (`DIV_WIDTH + 1)

// number of stage_if slots in the chain, prep output plus one per cell
`define DIV_STAGES (`DIV_WIDTH + 1)

// prep + one clock per quotient bit + fixup
`define DIV_LATENCY (`DIV_WIDTH + 2)

// most negative signed operand
`define DIV_INT_MIN {1'b1, {(`DIV_WIDTH-1){1'b0}}}

`endif

// ==== verilog/div_pkg.sv ====
package div_pkg;

    // low two bits of funct3 for the div group
    typedef enum logic [1:0] {
        op_div  = 2'b00,
        op_divu = 2'b01,
        op_rem  = 2'b10,
        op_remu = 2'b11
    } div_op_t;

    // flags that ride along with each operation through the cell chain
    typedef struct packed {
        logic neg_quo; // negate quotient at the end
        logic neg_rem; // negate remainder at the end
        logic sel_rem; // rem/remu, output remainder
    } div_side_t;

endpackage

// ==== verilog/div_stage_if.sv ====
`timescale 1ns/1ps

`include "div_consts.svh"

interface div_stage_if;

    logic                      valid;
    logic [`DIV_REM_WIDTH-1:0] rem;   // partial remainder
    logic [`DIV_WIDTH-1:0]     quo;   // quotient bits so far, lsb newest
    logic [`DIV_WIDTH-1:0]     dvd;   // dividend bits left, msb next
    logic [`DIV_WIDTH-1:0]     dsr;   // divisor magnitude
    div_pkg::div_side_t        side;

    modport src (
        output valid,
        output rem,
        output quo,
        output dvd,
        output dsr,
        output side
    );

    modport snk (
        input valid,
        input rem,
        input quo,
        input dvd,
        input dsr,
        input side
    );

endinterface

// ==== verilog/div_prep.sv ====
`timescale 1ns/1ps

`include "div_consts.svh"

module div_prep (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  in_valid,
    input  div_pkg::div_op_t      op,
    input  logic [`DIV_WIDTH-1:0] dividend,
    input  logic [`DIV_WIDTH-1:0] divisor,
    div_stage_if.src              out
);

    logic                  is_signed;
    logic                  dvd_neg;
    logic                  dsr_neg;
    logic                  dsr_zero;
    logic [`DIV_WIDTH-1:0] dvd_mag;
    logic [`DIV_WIDTH-1:0] dsr_mag;
    div_pkg::div_side_t    side_d;

    always_comb begin
        is_signed = (op == div_pkg::op_div) || (op == div_pkg::op_rem);
        dvd_neg   = is_signed && dividend[`DIV_WIDTH-1];
        dsr_neg   = is_signed && divisor[`DIV_WIDTH-1];
        dsr_zero  = (divisor == '0);

        // int_min maps onto itself, which is the right unsigned magnitude
        dvd_mag = dvd_neg ? (~dividend + 1'b1) : dividend;
        dsr_mag = dsr_neg ? (~divisor + 1'b1) : divisor;

        side_d.neg_rem = dvd_neg;
        side_d.neg_quo = (dvd_neg ^ dsr_neg) && !dsr_zero; // x/0 stays all ones
        side_d.sel_rem = (op == div_pkg::op_rem) || (op == div_pkg::op_remu);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid;
        end
    end

    // payload follows valid, no reset
    always_ff @(posedge clk) begin
        out.rem  <= '0;
        out.quo  <= '0;
        out.dvd  <= dvd_mag;
        out.dsr  <= dsr_mag;
        out.side <= side_d;
    end

    // decode above depends on a clean op
    a_op_known: assert property (
        @(posedge clk) disable iff (!rstn)
        in_valid |-> !$isunknown(op)
    ) else $error("div_prep: op unknown while in_valid high");

endmodule

// ==== verilog/divider_cell.sv ====
`timescale 1ns/1ps

`include "div_consts.svh"

module divider_cell (
    input  logic     clk,
    input  logic     rstn,
    div_stage_if.snk prev,
    div_stage_if.src next
);

    logic [`DIV_REM_WIDTH-1:0] rem_sh;
    logic [`DIV_REM_WIDTH-1:0] dsr_ext;
    logic [`DIV_REM_WIDTH-1:0] rem_sub;
    logic                      q_bit;
    logic [`DIV_REM_WIDTH-1:0] rem_d;
    logic [`DIV_WIDTH-1:0]     quo_d;
    logic [`DIV_WIDTH-1:0]     dvd_d;

    // low bits of the partial remainder hold all of it
    always_comb begin
        rem_sh  = {prev.rem[`DIV_WIDTH-1:0], prev.dvd[`DIV_WIDTH-1]};
        dsr_ext = {1'b0, prev.dsr};
        rem_sub = rem_sh - dsr_ext;
        q_bit   = (rem_sh >= dsr_ext); // dsr of zero always takes a one

        rem_d = q_bit ? rem_sub : rem_sh;
        quo_d = {prev.quo[`DIV_WIDTH-2:0], q_bit};
        dvd_d = {prev.dvd[`DIV_WIDTH-2:0], 1'b0}; // next bit moves to msb
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            next.valid <= 1'b0;
        end else begin
            next.valid <= prev.valid;
        end
    end

    always_ff @(posedge clk) begin
        next.rem  <= rem_d;
        next.quo  <= quo_d;
        next.dvd  <= dvd_d;
        next.dsr  <= prev.dsr;
        next.side <= prev.side;
    end

    // restoring step keeps the remainder below a nonzero divisor
    a_rem_below_dsr: assert property (
        @(posedge clk) disable iff (!rstn)
        next.valid && (next.dsr != '0) |-> next.rem < {1'b0, next.dsr}
    ) else $error("divider_cell: partial remainder not below divisor");

endmodule

// ==== verilog/div_fixup.sv ====
`timescale 1ns/1ps

`include "div_consts.svh"

module div_fixup (
    input  logic                  clk,
    input  logic                  rstn,
    div_stage_if.snk              last,
    output logic                  out_valid,
    output logic [`DIV_WIDTH-1:0] result
);

    logic [`DIV_WIDTH-1:0] quo_mag;
    logic [`DIV_WIDTH-1:0] rem_mag;
    logic [`DIV_WIDTH-1:0] quo_fix;
    logic [`DIV_WIDTH-1:0] rem_fix;
    logic [`DIV_WIDTH-1:0] result_d;

    always_comb begin
        quo_mag = last.quo;
        rem_mag = last.rem[`DIV_WIDTH-1:0]; // top bit is zero after last cell

        // truncating division, remainder follows the dividend sign
        quo_fix = last.side.neg_quo ? (~quo_mag + 1'b1) : quo_mag;
        rem_fix = last.side.neg_rem ? (~rem_mag + 1'b1) : rem_mag;

        // int_min / -1 comes out as int_min with rem 0 without help
        result_d = last.side.sel_rem ? rem_fix : quo_fix;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= last.valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= result_d;
    end

    // catches an x injected anywhere upstream in the chain
    a_result_known: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid |-> !$isunknown(result)
    ) else $error("div_fixup: result unknown while out_valid high");

endmodule

// ==== verilog/div_unit.sv ====
`timescale 1ns/1ps

`include "div_consts.svh"

module div_unit (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  in_valid,
    input  logic [1:0]            op,
    input  logic [`DIV_WIDTH-1:0] dividend,
    input  logic [`DIV_WIDTH-1:0] divisor,
    output logic                  out_valid,
    output logic [`DIV_WIDTH-1:0] result
);

    // slot 0 from prep, slot k+1 from cell k
    div_stage_if stage [`DIV_STAGES] ();

    div_prep u_prep (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .op       (div_pkg::div_op_t'(op)),
        .dividend (dividend),
        .divisor  (divisor),
        .out      (stage[0])
    );

    genvar k;
    generate
        for (k = 0; k < `DIV_WIDTH; k++) begin : g_cell
            divider_cell u_cell (
                .clk  (clk),
                .rstn (rstn),
                .prev (stage[k]),
                .next (stage[k+1])
            );
        end
    endgenerate

    div_fixup u_fixup (
        .clk       (clk),
        .rstn      (rstn),
        .last      (stage[`DIV_WIDTH]),
        .out_valid (out_valid),
        .result    (result)
    );

    // every issue shows up exactly DIV_LATENCY clocks later
    a_issue_to_result: assert property (
        @(posedge clk) disable iff (!rstn)
        $past(in_valid && rstn, `DIV_LATENCY) |-> out_valid
    ) else $error("div_unit: result missing at fixed latency");

    // and nothing comes out that was not issued
    a_no_spurious: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid |-> $past(in_valid && rstn, `DIV_LATENCY)
    ) else $error("div_unit: out_valid without matching issue");

endmodule

// ==== bench/div_unit_tb.sv ====
`timescale 1ns/1ps

`include "div_consts.svh"

module div_unit_tb;

    localparam int W   = `DIV_WIDTH;
    localparam int LAT = `DIV_LATENCY;
    localparam logic [W-1:0] INT_MIN = `DIV_INT_MIN;

    // one issued operation waiting for its result
    typedef struct {
        logic [1:0]   op;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] exp_val;
        int           cyc;
    } pend_t;

    logic         clk;
    logic         rstn;
    logic         in_valid;
    logic [1:0]   op;
    logic [W-1:0] dividend;
    logic [W-1:0] divisor;
    logic         out_valid;
    logic [W-1:0] result;

    int          cyc = 0;
    int          n_checked = 0;
    logic [31:0] lfsr = 32'd42;
    pend_t       pend_q [$];

    div_unit DUT (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // rv32m reference with truncating division and rem sign from the dividend
    function automatic logic [W-1:0] ref_result(input logic [1:0] o,
                                                input logic [W-1:0] a,
                                                input logic [W-1:0] b);
        logic signed [W-1:0] sa;
        logic signed [W-1:0] sb;
        logic                ovf;
        logic [W-1:0]        r;
        sa  = a;
        sb  = b;
        ovf = (a == INT_MIN) && (b == '1);
        case (o)
            div_pkg::op_divu: r = (b == '0) ? '1 : a / b;
            div_pkg::op_remu: r = (b == '0) ? a : a % b;
            div_pkg::op_div: begin
                if (b == '0)
                    r = '1;
                else if (ovf)
                    r = INT_MIN;
                else
                    r = sa / sb;
            end
            default: begin
                if (b == '0)
                    r = a;
                else if (ovf)
                    r = '0;
                else
                    r = sa % sb;
            end
        endcase
        return r;
    endfunction

    // holds the op for one clock from a negedge
    task automatic issue_op(input logic [1:0] o, input logic [W-1:0] a,
                            input logic [W-1:0] b);
        pend_t p;
        p.op      = o;
        p.a       = a;
        p.b       = b;
        p.exp_val = ref_result(o, a, b);
        p.cyc     = cyc;
        in_valid  = 1'b1;
        op        = o;
        dividend  = a;
        divisor   = b;
        pend_q.push_back(p);
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drain(input int limit);
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (pend_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (pend_q.size() == 0) else
            abort_run($sformatf("error at %0t: %0d results did not arrive in %0d cycles",
                                $time, pend_q.size(), limit));
    endtask

    // results checked at negedge where the outputs are settled
    initial begin : compare
        pend_t p;
        forever begin
            @(negedge clk);
            assert (pend_q.size() == 0 || out_valid || cyc - pend_q[0].cyc <= LAT) else
                abort_run($sformatf("error at %0t: no result arrived for op issued in cycle %0d",
                                    $time, pend_q[0].cyc));
            if (out_valid) begin
                assert (pend_q.size() != 0) else
                    abort_run($sformatf("error at %0t: out_valid high with nothing issued",
                                        $time));
                p = pend_q.pop_front();
                assert (cyc - p.cyc == LAT) else
                    abort_run($sformatf("mismatch at %0t: latency %0d, expected %0d",
                                        $time, cyc - p.cyc, LAT));
                assert (result === p.exp_val) else
                    abort_run($sformatf("mismatch at %0t: op %0d a %h b %h expected %h got %h",
                                        $time, p.op, p.a, p.b, p.exp_val, result));
                n_checked++;
            end
        end
    end

    initial begin : main
        int           i;
        int           j;
        logic [31:0]  bits;
        logic [1:0]   o;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] specials [6];

        rstn     = 1'b0;
        in_valid = 1'b0;
        op       = '0;
        dividend = '0;
        divisor  = '0;

        repeat (8) begin
            @(negedge clk);
            assert (out_valid === 1'b0) else
                abort_run("error: out_valid not low during reset");
        end
        rstn = 1'b1;

        // output stays quiet while nothing is issued
        for (i = 0; i < 2 * LAT; i++) begin
            @(negedge clk);
            assert (out_valid === 1'b0) else
                abort_run($sformatf("error at %0t: out_valid high before any issue", $time));
        end

        // unsigned ops issued back to back
        for (i = 0; i < 200; i++) begin
            take_bits(1, bits);
            o = bits[0] ? div_pkg::op_remu : div_pkg::op_divu;
            take_bits(W, bits);
            a = bits;
            take_bits(W, bits);
            b = bits;
            take_bits(5, bits);
            b = b >> bits[4:0]; // wider spread of quotient sizes
            issue_op(o, a, b);
        end
        drain(LAT + 10);

        // signed ops with i cycling through the four sign pairs
        for (i = 0; i < 200; i++) begin
            take_bits(1, bits);
            o = bits[0] ? div_pkg::op_rem : div_pkg::op_div;
            take_bits(W - 1, bits);
            a = {i[0], bits[W-2:0]};
            take_bits(W - 1, bits);
            b = {i[1], bits[W-2:0]};
            take_bits(5, bits);
            b = $signed(b) >>> bits[4:0]; // keeps the sign
            if (b == '0)
                b = 1;
            issue_op(o, a, b);
        end
        drain(LAT + 10);

        // divide by zero on all four ops
        specials[0] = '0;
        specials[1] = 1;
        specials[2] = INT_MIN;
        specials[3] = '1;
        specials[4] = 12345;
        take_bits(W, bits);
        specials[5] = bits;
        for (j = 0; j < 4; j++) begin
            for (i = 0; i < 6; i++) begin
                issue_op(j[1:0], specials[i], '0);
            end
        end
        drain(LAT + 10);

        // signed overflow and neighbours
        issue_op(div_pkg::op_div, INT_MIN, '1);
        issue_op(div_pkg::op_rem, INT_MIN, '1);
        issue_op(div_pkg::op_divu, INT_MIN, '1);
        issue_op(div_pkg::op_remu, INT_MIN, '1);
        issue_op(div_pkg::op_div, INT_MIN, 1);
        issue_op(div_pkg::op_div, INT_MIN, INT_MIN);
        issue_op(div_pkg::op_div, '1, INT_MIN);
        issue_op(div_pkg::op_rem, '1, INT_MIN);
        issue_op(div_pkg::op_rem, '1, '1);
        drain(LAT + 10);

        // random gaps between issues
        for (i = 0; i < 100; i++) begin
            take_bits(2, bits);
            o = bits[1:0];
            take_bits(W, bits);
            a = bits;
            take_bits(W, bits);
            b = bits;
            take_bits(5, bits);
            b = b >> bits[4:0];
            issue_op(o, a, b);
            take_bits(2, bits);
            idle(bits[1:0]);
        end
        drain(LAT + 10);
        idle(LAT); // no late pulses after the last result

        $display("%0d results checked", n_checked);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
verilog/div_pkg.sv
verilog/div_stage_if.sv
verilog/div_prep.sv
verilog/divider_cell.sv
verilog/div_fixup.sv
verilog/div_unit.sv
bench/div_unit_tb.sv
